// File: Makefile
VERILATOR  ?= verilator
TOP        := tb_target_net
FILELIST   := build.f
BUILD_DIR  := obj_dir
VFLAGS     := --binary --timing --assert --timescale 1ns/10ps -j 0
LINT_FLAGS := --lint-only -Wall --timing --timescale 1ns/10ps

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

// File: build.f
common/tnet_pkg.sv
hw/layer_ram.sv
hw/ann_memory.sv
feed_forward/ff_sequencer.sv
feed_forward/ff_neuron.sv
hw/q_max.sv
hw/target_net.sv
dv/target_net_properties.sv
dv/tb_target_net.sv

// File: common/tnet_pkg.sv
package tnet_pkg;

	localparam int DATA_W  = 16;	// data word width.
	localparam int FRAC_W  = 8;	// fraction bits of the fixed-point format.
	localparam int ACC_W   = 32;	// accumulator width.
	localparam int LAYER_W = 2;	// layer code width.
	localparam int NODE_W  = 3;	// node address, up to 8 nodes.
	localparam int WADDR_W = 6;	// flat weight index within a layer.

	localparam logic [LAYER_W-1:0] LAYER_IN  = 2'd0;	// input activations.
	localparam logic [LAYER_W-1:0] LAYER_OUT = 2'd3;	// output layer, stays linear.

	typedef logic signed [DATA_W-1:0] data_t;
	typedef logic signed [ACC_W-1:0]  acc_t;

	localparam data_t DATA_MAX = 16'sh7fff;
	localparam data_t DATA_MIN = 16'sh8000;

	typedef struct packed {
		logic               valid;
		logic [LAYER_W-1:0] layer;
		logic [WADDR_W-1:0] addr;
		data_t              data;
	} mem_wr_t;

	typedef struct packed {
		logic               valid;
		logic [LAYER_W-1:0] layer;
		logic [WADDR_W-1:0] addr;
	} mem_rd_t;

	// one multiply-accumulate step, product rescaled to the data format.
	function automatic acc_t fx_mac(acc_t acc, data_t w, data_t a);
		acc_t prod;
		prod = acc_t'(w) * acc_t'(a);
		return acc + (prod >>> FRAC_W);
	endfunction

	// saturate to a data word; leaky slope applies to negative hidden values.
	function automatic data_t fx_act(acc_t acc, logic leaky, int unsigned shift);
		data_t sat;
		if (acc > acc_t'(DATA_MAX))
			sat = DATA_MAX;
		else if (acc < acc_t'(DATA_MIN))
			sat = DATA_MIN;
		else
			sat = data_t'(acc);
		if (leaky && sat[DATA_W-1])
			sat = sat >>> shift;	// slope of 2^-shift.
		return sat;
	endfunction

endpackage

// File: dv/target_net_properties.sv
`timescale 1ns/10ps

module target_net_properties (
	input logic clk,
	input logic rst_n,
	input logic i_q_max_valid,
	input logic i_busy,
	input logic i_wb_valid
);

	// the result is a single-cycle pulse.
	a_pulse_width: assert property (@(posedge clk) disable iff (!rst_n)
		i_q_max_valid |=> !i_q_max_valid)
		else $error("o_q_max_valid stayed high for more than one cycle.");

	// busy drops on the same edge that raises the result.
	a_result_after_pass: assert property (@(posedge clk) disable iff (!rst_n)
		i_q_max_valid |-> $past(i_busy))
		else $error("o_q_max_valid rose while the sequencer was idle.");

	a_wb_in_pass: assert property (@(posedge clk) disable iff (!rst_n)
		i_wb_valid |-> i_busy)
		else $error("node write-back seen outside a forward pass.");

endmodule

bind target_net target_net_properties u_properties (
	.clk           (clk),
	.rst_n         (rst_n),
	.i_q_max_valid (o_q_max_valid),
	.i_busy        (seq_busy),
	.i_wb_valid    (fw_data.valid)
);

// File: dv/tb_target_net.sv
`timescale 1ns/10ps

module tb_target_net;

	import tnet_pkg::*;

	localparam int N_IN        = 2;
	localparam int N_H1        = 8;
	localparam int N_H2        = 8;
	localparam int N_OUT       = 3;
	localparam int ALPHA_SHIFT = 3;
	localparam int CLK_PERIOD  = 40;
	localparam int N_PASSES    = 13;	// 1 + 8 + 1 + 1 + 2 over all tests.
	localparam int PASS_CYCLES = 300;	// generous bound for one pass.
	localparam int RAND_SPAN   = 512;	// +-2.0 in the data format.

	logic               clk = 1'b0;
	logic               rst_n;
	logic               i_data_valid;
	logic [NODE_W-1:0]  i_data_addr;
	data_t              i_data;
	logic               i_weight_valid;
	logic [LAYER_W-1:0] i_weight_layer;
	logic [WADDR_W-1:0] i_weight_addr;
	data_t              i_weight;
	logic               o_q_max_valid;
	data_t              o_q_max;

	data_t       x_in [N_IN];	// current network inputs.
	data_t       w1 [N_IN*N_H1];
	data_t       w2 [N_H1*N_H2];
	data_t       w3 [N_H2*N_OUT];
	logic [31:0] rng = 32'd95;
	data_t       exp_q [$];	// expected maximum per started pass.
	string       name_q [$];
	int          passes_started = 0;
	int          results_seen = 0;

	target_net #(
		.N_IN        (N_IN),
		.N_H1        (N_H1),
		.N_H2        (N_H2),
		.N_OUT       (N_OUT),
		.ALPHA_SHIFT (ALPHA_SHIFT)
	) UUT (
		.clk            (clk),
		.rst_n          (rst_n),
		.i_data_valid   (i_data_valid),
		.i_data_addr    (i_data_addr),
		.i_data         (i_data),
		.i_weight_valid (i_weight_valid),
		.i_weight_layer (i_weight_layer),
		.i_weight_addr  (i_weight_addr),
		.i_weight       (i_weight),
		.o_q_max_valid  (o_q_max_valid),
		.o_q_max        (o_q_max)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	task automatic fail_run(input string reason);
		$display("%s", reason);
		$display("Simulation failed");
		$fatal(1);
	endtask

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] v;
		v = s;
		v = v ^ (v << 13);
		v = v ^ (v >> 17);
		v = v ^ (v << 5);
		return v;
	endfunction

	// uniform value in -span..span.
	function automatic data_t rand_fx(input int span);
		int r;
		rng = xorshift32(rng);
		r = int'(rng % 32'(2 * span + 1)) - span;
		return data_t'(r);
	endfunction

	function automatic data_t rand_mag(input int span);
		rng = xorshift32(rng);
		return data_t'(int'(rng % 32'(span + 1)));
	endfunction

	// product in Q8.8 is truncated back to 8 fraction bits before the add.
	function automatic int mac_step(input int acc, input data_t w, input data_t a);
		int prod;
		prod = int'(w) * int'(a);
		return acc + (prod >>> FRAC_W);
	endfunction

	function automatic data_t activate(input int acc, input bit leaky);
		int v;
		if (acc > 32767)
			v = 32767;
		else if (acc < -32768)
			v = -32768;
		else
			v = acc;
		if (leaky && v < 0)
			v = v >>> ALPHA_SHIFT;	// floor of v / 2^alpha.
		return data_t'(v);
	endfunction

	function automatic data_t ref_qmax();
		int    acc;
		int    n;
		int    i;
		data_t h1 [N_H1];
		data_t h2 [N_H2];
		data_t q;
		data_t best;
		best = 16'sd0;
		for (n = 0; n < N_H1; n++) begin
			acc = 0;
			for (i = 0; i < N_IN; i++)
				acc = mac_step(acc, w1[n*N_IN+i], x_in[i]);
			h1[n] = activate(acc, 1'b1);
		end
		for (n = 0; n < N_H2; n++) begin
			acc = 0;
			for (i = 0; i < N_H1; i++)
				acc = mac_step(acc, w2[n*N_H1+i], h1[i]);
			h2[n] = activate(acc, 1'b1);
		end
		for (n = 0; n < N_OUT; n++) begin
			acc = 0;
			for (i = 0; i < N_H2; i++)
				acc = mac_step(acc, w3[n*N_H2+i], h2[i]);
			q = activate(acc, 1'b0);	// output nodes stay linear.
			if (n == 0 || q > best)
				best = q;
		end
		return best;
	endfunction

	task automatic drive_weight(input logic [LAYER_W-1:0] layer, input int addr, input data_t value);
		@(negedge clk);
		i_weight_valid = 1'b1;
		i_weight_layer = layer;
		i_weight_addr  = WADDR_W'(addr);
		i_weight       = value;
	endtask

	task automatic load_weights();
		int j;
		for (j = 0; j < N_IN * N_H1; j++)
			drive_weight(2'd1, j, w1[j]);
		for (j = 0; j < N_H1 * N_H2; j++)
			drive_weight(2'd2, j, w2[j]);
		for (j = 0; j < N_H2 * N_OUT; j++)
			drive_weight(2'd3, j, w3[j]);
		@(negedge clk);
		i_weight_valid = 1'b0;
	endtask

	task automatic write_input(input int addr, input data_t value);
		@(negedge clk);
		i_data_valid = 1'b1;
		i_data_addr  = NODE_W'(addr);
		i_data       = value;
	endtask

	task automatic end_data_write();
		@(negedge clk);
		i_data_valid = 1'b0;
	endtask

	task automatic expect_result(input string name);
		exp_q.push_back(ref_qmax());
		name_q.push_back(name);
		passes_started++;
	endtask

	task automatic wait_results();
		int cycles;
		cycles = 0;
		while (results_seen < passes_started) begin
			@(negedge clk);
			cycles++;
			if (cycles > PASS_CYCLES)
				fail_run($sformatf("no result pulse within %0d cycles of a pass start",
					PASS_CYCLES));
		end
	endtask

	// the last input address is written last, so it starts the pass.
	task automatic run_pass(input string name);
		int j;
		expect_result(name);
		for (j = 0; j < N_IN; j++)
			write_input(j, x_in[j]);
		end_data_write();
		wait_results();
	endtask

	task automatic fill_random();
		int j;
		for (j = 0; j < N_IN * N_H1; j++)
			w1[j] = rand_fx(RAND_SPAN);
		for (j = 0; j < N_H1 * N_H2; j++)
			w2[j] = rand_fx(RAND_SPAN);
		for (j = 0; j < N_H2 * N_OUT; j++)
			w3[j] = rand_fx(RAND_SPAN);
		for (j = 0; j < N_IN; j++)
			x_in[j] = rand_fx(RAND_SPAN);
	endtask

	task automatic idle_after_reset();
		repeat (20) begin
			@(negedge clk);
			assert (o_q_max_valid == 1'b0)
				else fail_run("result pulse seen after reset without any stimulus");
		end
	endtask

	task automatic identity_weights();
		int n;
		int i;
		for (n = 0; n < N_H1; n++) begin
			for (i = 0; i < N_IN; i++)
				w1[n*N_IN+i] = (i == n % N_IN) ? 16'sd256 : 16'sd0;
		end
		for (n = 0; n < N_H2; n++) begin
			for (i = 0; i < N_H1; i++)
				w2[n*N_H1+i] = (i == n) ? 16'sd256 : 16'sd0;
		end
		for (n = 0; n < N_OUT; n++) begin
			for (i = 0; i < N_H2; i++)
				w3[n*N_H2+i] = (i == n) ? data_t'(256 + 64 * n) : 16'sd0;	// distinct gains.
		end
		x_in[0] = 16'sd384;
		x_in[1] = 16'sd192;
		load_weights();
		run_pass("identity");
	endtask

	task automatic random_reloads();
		int p;
		for (p = 0; p < 8; p++) begin
			fill_random();
			load_weights();
			run_pass($sformatf("random_%0d", p));
		end
	endtask

	// negative hidden sums, then negative q values.
	task automatic leaky_and_signed_max();
		int j;
		for (j = 0; j < N_IN * N_H1; j++)
			w1[j] = -rand_mag(RAND_SPAN);
		for (j = 0; j < N_H1 * N_H2; j++)
			w2[j] = rand_mag(RAND_SPAN);
		for (j = 0; j < N_H2 * N_OUT; j++)
			w3[j] = rand_mag(RAND_SPAN);
		for (j = 0; j < N_IN; j++)
			x_in[j] = rand_mag(RAND_SPAN);
		load_weights();
		run_pass("leaky_negative");
	endtask

	task automatic saturated_sums();
		int j;
		for (j = 0; j < N_IN * N_H1; j++)
			w1[j] = 16'sh7fff;
		for (j = 0; j < N_H1 * N_H2; j++)
			w2[j] = 16'sh7fff;
		for (j = 0; j < N_H2 * N_OUT; j++)
			w3[j] = (j < N_H2) ? 16'sh7fff : ((j < 2 * N_H2) ? 16'sh8000 : 16'sh0010);
		for (j = 0; j < N_IN; j++)
			x_in[j] = 16'sh7fff;
		load_weights();
		run_pass("saturation");
	endtask

	task automatic rewrite_inputs();
		int j;
		fill_random();
		load_weights();
		run_pass("rewrite_first");
		for (j = 0; j < N_IN; j++)
			x_in[j] = rand_fx(RAND_SPAN);
		for (j = 0; j < N_IN - 1; j++)
			write_input(j, x_in[j]);
		end_data_write();
		// long enough for a wrongly started pass to reach its result.
		repeat (PASS_CYCLES) begin
			@(negedge clk);
			assert (o_q_max_valid == 1'b0)
				else fail_run("a pass ran before the last input address was written");
		end
		expect_result("rewrite_second");	// weights stay from the first pass.
		write_input(N_IN - 1, x_in[N_IN - 1]);
		end_data_write();
		wait_results();
	endtask

	always @(negedge clk) begin : compare_results
		data_t expected;
		string name;
		if (rst_n && o_q_max_valid) begin
			assert (exp_q.size() > 0)
				else fail_run("result pulse arrived with no pass pending");
			expected = exp_q.pop_front();
			name     = name_q.pop_front();
			assert (o_q_max == expected)
				else fail_run($sformatf("MISMATCH test=%s expected=%0d actual=%0d",
					name, expected, o_q_max));
			results_seen++;
		end
	end

	initial begin : watchdog
		#(2 * N_PASSES * PASS_CYCLES * CLK_PERIOD);
		fail_run("watchdog expired before the tests finished");
	end

	initial begin : stimulus
		rst_n          = 1'b0;
		i_data_valid   = 1'b0;
		i_data_addr    = '0;
		i_data         = '0;
		i_weight_valid = 1'b0;
		i_weight_layer = '0;
		i_weight_addr  = '0;
		i_weight       = '0;
		repeat (3) @(negedge clk);
		rst_n = 1'b1;
		idle_after_reset();
		identity_weights();
		random_reloads();
		leaky_and_signed_max();
		saturated_sums();
		rewrite_inputs();
		repeat (50) @(negedge clk);	// room for a stray extra pulse.
		if (exp_q.size() == 0 && results_seen == passes_started) begin
			$display("Simulation completed successfully");
			$finish;
		end else begin
			fail_run("not every started pass produced a result");
		end
	end

endmodule

// File: feed_forward/ff_neuron.sv
`timescale 1ns/10ps

module ff_neuron #(
	parameter int ALPHA_SHIFT = 3
) (
	input  logic                         clk,
	input  logic                         rst_n,
	input  logic                         i_rd_valid,
	input  tnet_pkg::data_t              i_weight,
	input  tnet_pkg::data_t              i_act,
	input  logic [tnet_pkg::LAYER_W-1:0] i_tag_layer,
	input  logic [tnet_pkg::NODE_W-1:0]  i_tag_node,
	input  logic                         i_tag_first,
	input  logic                         i_tag_last,
	output tnet_pkg::mem_wr_t            o_wb,
	output logic                         o_q_valid,
	output tnet_pkg::data_t              o_q
);

	import tnet_pkg::*;

	acc_t               acc_q;
	acc_t               acc_sum;	// accumulator including the current pair.
	logic               hidden;
	logic               done;
	data_t              act_val;
	logic               wb_valid_q;
	logic [LAYER_W-1:0] wb_layer_q;
	logic [WADDR_W-1:0] wb_addr_q;
	data_t              wb_data_q;
	logic               q_valid_q;

	assign hidden  = i_tag_layer != LAYER_OUT;
	assign done    = i_rd_valid && i_tag_last;
	assign acc_sum = fx_mac(i_tag_first ? acc_t'(0) : acc_q, i_weight, i_act);
	assign act_val = fx_act(acc_sum, hidden, ALPHA_SHIFT);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			acc_q      <= '0;
			wb_valid_q <= 1'b0;
			q_valid_q  <= 1'b0;
		end else begin
			if (i_rd_valid)
				acc_q <= acc_sum;
			wb_valid_q <= done;
			q_valid_q  <= done && !hidden;	// output nodes also go to the max unit.
		end
	end

	always_ff @(posedge clk) begin
		if (done) begin
			wb_layer_q <= i_tag_layer;
			wb_addr_q  <= WADDR_W'(i_tag_node);
			wb_data_q  <= act_val;
		end
	end

	assign o_wb      = '{valid: wb_valid_q, layer: wb_layer_q, addr: wb_addr_q, data: wb_data_q};
	assign o_q_valid = q_valid_q;
	assign o_q       = wb_data_q;

endmodule

// File: feed_forward/ff_sequencer.sv
`timescale 1ns/10ps

module ff_sequencer #(
	parameter int N_IN  = 2,
	parameter int N_H1  = 8,
	parameter int N_H2  = 8,
	parameter int N_OUT = 3
) (
	input  logic                         clk,
	input  logic                         rst_n,
	input  tnet_pkg::mem_wr_t            i_ext_data,
	output tnet_pkg::mem_rd_t            o_weight_rd,
	output tnet_pkg::mem_rd_t            o_act_rd,
	output logic [tnet_pkg::LAYER_W-1:0] o_tag_layer,
	output logic [tnet_pkg::NODE_W-1:0]  o_tag_node,
	output logic                         o_tag_first,
	output logic                         o_tag_last,
	output logic                         o_busy
);

	import tnet_pkg::*;

	localparam int WAIT_CYCLES = 2;	// last input reaches the ram.
	localparam int GAP_CYCLES  = 3;	// last write-back lands before next layer.

	typedef enum logic [1:0] {
		S_IDLE,
		S_WAIT,
		S_RUN,
		S_GAP
	} state_t;

	typedef struct packed {
		logic [LAYER_W-1:0] layer;
		logic [NODE_W-1:0]  node;
		logic               first;
		logic               last;
	} tag_t;

	state_t             state_q;
	logic [LAYER_W-1:0] layer_q;
	logic [NODE_W-1:0]  node_q;
	logic [NODE_W-1:0]  idx_q;
	logic [WADDR_W-1:0] waddr_q;	// node * fan-in + idx, walked flat.
	logic [1:0]         cnt_q;
	logic [NODE_W-1:0]  fan_in_m1;
	logic [NODE_W-1:0]  nodes_m1;
	logic               start;
	logic               run;
	tag_t               tag_now;
	tag_t               tag_d1;
	tag_t               tag_d2;

	always_comb begin
		unique case (layer_q)
			2'd1: begin
				fan_in_m1 = NODE_W'(N_IN - 1);
				nodes_m1  = NODE_W'(N_H1 - 1);
			end
			2'd2: begin
				fan_in_m1 = NODE_W'(N_H1 - 1);
				nodes_m1  = NODE_W'(N_H2 - 1);
			end
			default: begin
				fan_in_m1 = NODE_W'(N_H2 - 1);
				nodes_m1  = NODE_W'(N_OUT - 1);
			end
		endcase
	end

	assign start = i_ext_data.valid && i_ext_data.layer == LAYER_IN &&
		i_ext_data.addr == WADDR_W'(N_IN - 1);
	assign run   = state_q == S_RUN;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state_q <= S_IDLE;
			layer_q <= 2'd1;
			node_q  <= '0;
			idx_q   <= '0;
			waddr_q <= '0;
			cnt_q   <= '0;
		end else begin
			unique case (state_q)
				S_IDLE: begin
					if (start) begin
						state_q <= S_WAIT;
						layer_q <= 2'd1;
						node_q  <= '0;
						idx_q   <= '0;
						waddr_q <= '0;
						cnt_q   <= '0;
					end
				end
				S_WAIT: begin
					cnt_q <= cnt_q + 1'b1;
					if (cnt_q == 2'(WAIT_CYCLES - 1))
						state_q <= S_RUN;
				end
				S_RUN: begin
					waddr_q <= waddr_q + 1'b1;
					if (idx_q == fan_in_m1) begin
						idx_q <= '0;
						if (node_q == nodes_m1) begin
							node_q  <= '0;
							cnt_q   <= '0;
							state_q <= S_GAP;
						end else begin
							node_q <= node_q + 1'b1;
						end
					end else begin
						idx_q <= idx_q + 1'b1;
					end
				end
				default: begin	// S_GAP, also drains the output layer.
					cnt_q <= cnt_q + 1'b1;
					if (cnt_q == 2'(GAP_CYCLES - 1)) begin
						waddr_q <= '0;
						if (layer_q == LAYER_OUT) begin
							state_q <= S_IDLE;
						end else begin
							layer_q <= layer_q + 1'b1;
							state_q <= S_RUN;
						end
					end
				end
			endcase
		end
	end

	assign o_weight_rd = '{valid: run, layer: layer_q, addr: waddr_q};
	assign o_act_rd    = '{valid: run, layer: layer_q - 2'd1, addr: WADDR_W'(idx_q)};

	assign tag_now = '{layer: layer_q, node: node_q, first: idx_q == '0,
		last: idx_q == fan_in_m1};

	// two stages, matching the request register and the ram read.
	always_ff @(posedge clk) begin
		tag_d1 <= tag_now;
		tag_d2 <= tag_d1;
	end

	assign o_tag_layer = tag_d2.layer;
	assign o_tag_node  = tag_d2.node;
	assign o_tag_first = tag_d2.first;
	assign o_tag_last  = tag_d2.last;
	assign o_busy      = state_q != S_IDLE;

endmodule

// File: hw/ann_memory.sv
`timescale 1ns/10ps

module ann_memory (
	input  logic              clk,
	input  logic              rst_n,
	input  tnet_pkg::mem_wr_t i_ext_data,
	input  tnet_pkg::mem_wr_t i_ext_weight,
	input  tnet_pkg::mem_wr_t i_fw_data,
	input  tnet_pkg::mem_rd_t i_weight_rd,
	input  tnet_pkg::mem_rd_t i_act_rd,
	output tnet_pkg::data_t   o_weight,
	output tnet_pkg::data_t   o_act,
	output logic              o_rd_valid
);

	import tnet_pkg::*;

	localparam int WT_AW  = LAYER_W + WADDR_W;	// weight ram, one bank per layer.
	localparam int ACT_AW = LAYER_W + NODE_W;	// activation ram, one bank per layer.

	mem_wr_t act_wr;	// selected activation write source.

	logic              wt_we_q;
	logic              wt_re_q;
	logic [WT_AW-1:0]  wt_addr_q;
	data_t             wt_wdata_q;
	logic              act_we_q;
	logic [ACT_AW-1:0] act_waddr_q;
	data_t             act_wdata_q;
	logic              act_re_q;
	logic [ACT_AW-1:0] act_raddr_q;
	logic              rd_valid_q;

	// external input writes win over the write-back.
	assign act_wr = i_ext_data.valid ? i_ext_data : i_fw_data;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wt_we_q    <= 1'b0;
			wt_re_q    <= 1'b0;
			act_we_q   <= 1'b0;
			act_re_q   <= 1'b0;
			rd_valid_q <= 1'b0;
		end else begin
			wt_we_q    <= i_ext_weight.valid;
			wt_re_q    <= !i_ext_weight.valid && i_weight_rd.valid;	// read loses to a load.
			act_we_q   <= act_wr.valid;
			act_re_q   <= i_act_rd.valid;
			rd_valid_q <= wt_re_q && act_re_q;	// lines up with the ram data.
		end
	end

	always_ff @(posedge clk) begin
		if (i_ext_weight.valid)
			wt_addr_q <= {i_ext_weight.layer, i_ext_weight.addr};
		else
			wt_addr_q <= {i_weight_rd.layer, i_weight_rd.addr};
		wt_wdata_q  <= i_ext_weight.data;
		act_waddr_q <= {act_wr.layer, act_wr.addr[NODE_W-1:0]};
		act_wdata_q <= act_wr.data;
		act_raddr_q <= {i_act_rd.layer, i_act_rd.addr[NODE_W-1:0]};
	end

	layer_ram #(
		.t_data  (data_t),
		.DEPTH_W (WT_AW)
	) u_weight_ram (
		.clk     (clk),
		.i_we    (wt_we_q),
		.i_waddr (wt_addr_q),
		.i_wdata (wt_wdata_q),
		.i_re    (wt_re_q),
		.i_raddr (wt_addr_q),
		.o_rdata (o_weight)
	);

	layer_ram #(
		.t_data  (data_t),
		.DEPTH_W (ACT_AW)
	) u_act_ram (
		.clk     (clk),
		.i_we    (act_we_q),
		.i_waddr (act_waddr_q),
		.i_wdata (act_wdata_q),
		.i_re    (act_re_q),
		.i_raddr (act_raddr_q),
		.o_rdata (o_act)
	);

	assign o_rd_valid = rd_valid_q;

endmodule

// File: hw/layer_ram.sv
`timescale 1ns/10ps

module layer_ram #(
	parameter type t_data = logic [15:0],
	parameter int  DEPTH_W = 4
) (
	input  logic               clk,
	input  logic               i_we,
	input  logic [DEPTH_W-1:0] i_waddr,
	input  t_data              i_wdata,
	input  logic               i_re,
	input  logic [DEPTH_W-1:0] i_raddr,
	output t_data              o_rdata
);

	localparam int DEPTH = 2 ** DEPTH_W;

	t_data mem [DEPTH];	// storage array.

	always_ff @(posedge clk) begin
		if (i_we)
			mem[i_waddr] <= i_wdata;
	end

	// read returns the old word on a same-address write.
	always_ff @(posedge clk) begin
		if (i_re)
			o_rdata <= mem[i_raddr];
	end

endmodule

// File: hw/q_max.sv
`timescale 1ns/10ps

module q_max #(
	parameter int N_OUT = 3
) (
	input  logic            clk,
	input  logic            rst_n,
	input  logic            i_valid,
	input  tnet_pkg::data_t i_data,
	output logic            o_valid,
	output tnet_pkg::data_t o_data
);

	import tnet_pkg::*;

	localparam int CNT_W = $clog2(N_OUT + 1);

	logic [CNT_W-1:0] cnt_q;
	data_t            max_q;
	data_t            max_next;	// signed max including this strobe.
	logic             last;

	assign max_next = (cnt_q == '0 || i_data > max_q) ? i_data : max_q;
	assign last     = cnt_q == CNT_W'(N_OUT - 1);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cnt_q   <= '0;
			o_valid <= 1'b0;
		end else begin
			o_valid <= i_valid && last;
			if (i_valid)
				cnt_q <= last ? '0 : cnt_q + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (i_valid) begin
			max_q <= max_next;
			if (last)
				o_data <= max_next;
		end
	end

endmodule

// File: hw/target_net.sv
`timescale 1ns/10ps

module target_net #(
	parameter int N_IN        = 2,
	parameter int N_H1        = 8,
	parameter int N_H2        = 8,
	parameter int N_OUT       = 3,
	parameter int ALPHA_SHIFT = 3
) (
	input  logic                         clk,
	input  logic                         rst_n,
	input  logic                         i_data_valid,
	input  logic [tnet_pkg::NODE_W-1:0]  i_data_addr,
	input  tnet_pkg::data_t              i_data,
	input  logic                         i_weight_valid,
	input  logic [tnet_pkg::LAYER_W-1:0] i_weight_layer,
	input  logic [tnet_pkg::WADDR_W-1:0] i_weight_addr,
	input  tnet_pkg::data_t              i_weight,
	output logic                         o_q_max_valid,
	output tnet_pkg::data_t              o_q_max
);

	import tnet_pkg::*;

	mem_wr_t            ext_data;
	mem_wr_t            ext_weight;
	mem_wr_t            fw_data;	// node write-back.
	mem_rd_t            weight_rd;
	mem_rd_t            act_rd;
	data_t              mem_weight;
	data_t              mem_act;
	logic               rd_valid;
	logic [LAYER_W-1:0] tag_layer;
	logic [NODE_W-1:0]  tag_node;
	logic               tag_first;
	logic               tag_last;
	logic               seq_busy;
	logic               q_valid;
	data_t              q_data;

	// inputs always land in layer 0.
	assign ext_data   = '{valid: i_data_valid, layer: LAYER_IN,
		addr: WADDR_W'(i_data_addr), data: i_data};
	assign ext_weight = '{valid: i_weight_valid, layer: i_weight_layer,
		addr: i_weight_addr, data: i_weight};

	ann_memory u_memory (
		.clk          (clk),
		.rst_n        (rst_n),
		.i_ext_data   (ext_data),
		.i_ext_weight (ext_weight),
		.i_fw_data    (fw_data),
		.i_weight_rd  (weight_rd),
		.i_act_rd     (act_rd),
		.o_weight     (mem_weight),
		.o_act        (mem_act),
		.o_rd_valid   (rd_valid)
	);

	ff_sequencer #(
		.N_IN  (N_IN),
		.N_H1  (N_H1),
		.N_H2  (N_H2),
		.N_OUT (N_OUT)
	) u_sequencer (
		.clk         (clk),
		.rst_n       (rst_n),
		.i_ext_data  (ext_data),
		.o_weight_rd (weight_rd),
		.o_act_rd    (act_rd),
		.o_tag_layer (tag_layer),
		.o_tag_node  (tag_node),
		.o_tag_first (tag_first),
		.o_tag_last  (tag_last),
		.o_busy      (seq_busy)
	);

	ff_neuron #(
		.ALPHA_SHIFT (ALPHA_SHIFT)
	) u_neuron (
		.clk         (clk),
		.rst_n       (rst_n),
		.i_rd_valid  (rd_valid),
		.i_weight    (mem_weight),
		.i_act       (mem_act),
		.i_tag_layer (tag_layer),
		.i_tag_node  (tag_node),
		.i_tag_first (tag_first),
		.i_tag_last  (tag_last),
		.o_wb        (fw_data),
		.o_q_valid   (q_valid),
		.o_q         (q_data)
	);

	q_max #(
		.N_OUT (N_OUT)
	) u_q_max (
		.clk     (clk),
		.rst_n   (rst_n),
		.i_valid (q_valid),
		.i_data  (q_data),
		.o_valid (o_q_max_valid),
		.o_data  (o_q_max)
	);

endmodule
